/* hdl/apb_port.sv */
module apb_port (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [11:0]          paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic                 complete,
    input  logic                 insn_error,
    input  logic [31:0]          rd_half_data,
    output logic                 issue,
    output tinker_pkg::insn_u    insn,
    output logic                 reg_we,
    output tinker_pkg::reg_idx_t reg_idx,
    output logic                 reg_hi,
    output logic [31:0]          reg_wdata
);
    import tinker_pkg::*;

    logic access;
    logic is_insn;
    logic is_reg;
    logic insn_wr;
    logic in_wait;
    logic busy;
    logic rsp_ready;
    logic rsp_err;

    assign access = psel & penable;

    // address decode, word aligned only
    assign is_insn = (paddr == ADDR_INSN);
    assign is_reg  = (paddr[11:8] == ADDR_REG_BASE[11:8]) && (paddr[1:0] == 2'b00);
    assign insn_wr = is_insn & pwrite;

    // 8 bytes per register, bit 2 picks the half
    assign reg_idx   = paddr[7:3];
    assign reg_hi    = paddr[2];
    assign reg_wdata = pwdata;
    assign reg_we    = access & pwrite & is_reg;
    assign prdata    = (!pwrite && is_reg) ? rd_half_data : 32'h0;

    assign insn = pwdata;

    // high while the previous cycle was a wait state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_wait <= 1'b0;
        end else begin
            in_wait <= access & ~pready;
        end
    end

    // issue only in the first access cycle
    assign issue = access & insn_wr & ~in_wait;

    // one instruction in flight
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            rsp_ready <= 1'b0;
            rsp_err   <= 1'b0;
        end else begin
            if (issue) begin
                busy <= 1'b1;
            end else if (complete) begin
                busy <= 1'b0;
            end
            // response one cycle behind complete
            rsp_ready <= complete;
            rsp_err   <= complete & insn_error;
        end
    end

    // register and unmapped accesses need no wait states
    assign pready  = insn_wr ? rsp_ready : 1'b1;
    assign pslverr = access & (insn_wr ? rsp_err : ~is_reg);

    // master must wait out the instruction before the next issue
    a_no_issue_busy: assert property (@(posedge clk) disable iff (reset) issue |-> !busy);

    // register file only finishes what was issued
    a_complete_busy: assert property (@(posedge clk) disable iff (reset) complete |-> busy);

endmodule

/* hdl/arith_unit.sv */
module arith_unit #(
    parameter int MUL_STEPS = 64
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  tinker_pkg::unit_req_t req,
    output tinker_pkg::unit_rsp_t rsp
);
    import tinker_pkg::*;

    // multiplier bits retired each cycle
    localparam int BITS_PER_STEP = WORD_W / MUL_STEPS;
    localparam int CNT_W         = $clog2(MUL_STEPS + 1);

    logic             mul_busy;
    logic [CNT_W-1:0] count;
    logic             done_q;
    word_t            value_q;
    word_t            acc;
    word_t            mcand;
    word_t            mplier;
    word_t            src_acc;
    word_t            src_mcand;
    word_t            src_mplier;
    word_t            step_sum;
    logic             is_mul;
    logic             last_step;

    assign is_mul = (req.opcode == OP_MUL);

    // first step runs on the start edge straight from the operands
    assign src_acc    = start ? '0 : acc;
    assign src_mcand  = start ? req.operand_a : mcand;
    assign src_mplier = start ? req.operand_b : mplier;

    // shift-add over this step's multiplier bits, low 64 bits kept
    always_comb begin
        step_sum = src_acc;
        for (int j = 0; j < BITS_PER_STEP; j++) begin
            if (src_mplier[j]) begin
                step_sum = step_sum + (src_mcand << j);
            end
        end
    end

    assign last_step = start ? (MUL_STEPS == 1) : (count == CNT_W'(1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mul_busy <= 1'b0;
            count    <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start && !is_mul) begin
                done_q <= 1'b1;
            end else if ((start && is_mul) || mul_busy) begin
                mul_busy <= ~last_step;
                count    <= start ? CNT_W'(MUL_STEPS - 1) : count - 1'b1;
                done_q   <= last_step;
            end
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (start && !is_mul) begin
            // addi and subi arrive with rd as operand a
            if (req.opcode == OP_SUB || req.opcode == OP_SUBI) begin
                value_q <= req.operand_a - req.operand_b;
            end else begin
                value_q <= req.operand_a + req.operand_b;
            end
        end else if ((start && is_mul) || mul_busy) begin
            acc     <= step_sum;
            mcand   <= src_mcand << BITS_PER_STEP;
            mplier  <= src_mplier >> BITS_PER_STEP;
            value_q <= step_sum;
        end
    end

    assign rsp.done  = done_q;
    assign rsp.value = value_q;

    a_no_start_mul: assert property (@(posedge clk) disable iff (reset) start |-> !mul_busy);

endmodule

/* hdl/logic_unit.sv */
module logic_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  tinker_pkg::unit_req_t req,
    output tinker_pkg::unit_rsp_t rsp
);
    import tinker_pkg::*;

    word_t a;
    word_t b;
    word_t result;
    logic  shift_big;
    logic  done_q;
    word_t value_q;

    assign a = req.operand_a;
    assign b = req.operand_b;

    // shift of 64 or more clears the word
    assign shift_big = |b[63:6];

    always_comb begin
        case (req.opcode)
            OP_AND:           result = a & b;
            OP_OR:            result = a | b;
            OP_XOR:           result = a ^ b;
            OP_NOT:           result = ~a;
            OP_SHR, OP_SHRI:  result = shift_big ? '0 : a >> b[5:0];
            OP_SHL, OP_SHLI:  result = shift_big ? '0 : a << b[5:0];
            OP_MOV:           result = a;
            // movl keeps the top 52 bits of rd
            OP_MOVL:          result = {a[63:12], b[11:0]};
            default:          result = '0;
        endcase
    end

    // done one cycle after start
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            value_q <= result;
        end
    end

    assign rsp.done  = done_q;
    assign rsp.value = value_q;

endmodule

/* hdl/reg_file.sv */
module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue,
    input  tinker_pkg::insn_u      insn,
    input  logic                   reg_we,
    input  tinker_pkg::reg_idx_t   reg_idx,
    input  logic                   reg_hi,
    input  logic [31:0]            reg_wdata,
    input  tinker_pkg::unit_rsp_t  arith_rsp,
    input  tinker_pkg::unit_rsp_t  logic_rsp,
    output logic [31:0]            rd_half_data,
    output tinker_pkg::unit_req_t  req,
    output logic                   arith_start,
    output logic                   logic_start,
    output logic                   complete,
    output logic                   insn_error
);
    import tinker_pkg::*;

    word_t     regs [NUM_REGS];
    opcode_e   opcode;
    reg_idx_t  rd;
    word_t     literal;
    logic      is_lit;
    logic      use_rd;
    logic      is_arith;
    logic      is_logic;
    logic      pending;
    logic      owner_arith;
    logic      bad_op;
    reg_idx_t  dest;
    unit_rsp_t owner_rsp;

    assign opcode  = insn.reg_form.opcode;
    assign rd      = insn.reg_form.rd;
    // 12-bit literal, sign extended
    assign literal = {{52{insn.lit_form.literal[11]}}, insn.lit_form.literal};

    // owner unit and operand sources per opcode
    always_comb begin
        is_lit   = 1'b0;
        use_rd   = 1'b0;
        is_arith = 1'b0;
        is_logic = 1'b0;
        case (opcode)
            OP_ADD, OP_SUB, OP_MUL: begin
                is_arith = 1'b1;
            end
            OP_ADDI, OP_SUBI: begin
                is_arith = 1'b1;
                is_lit   = 1'b1;
                use_rd   = 1'b1;
            end
            OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHR, OP_SHL, OP_MOV: begin
                is_logic = 1'b1;
            end
            OP_SHRI, OP_SHLI: begin
                is_logic = 1'b1;
                is_lit   = 1'b1;
            end
            OP_MOVL: begin
                is_logic = 1'b1;
                is_lit   = 1'b1;
                use_rd   = 1'b1;
            end
            default: begin
                is_lit = 1'b0;
            end
        endcase
    end

    // operand a is rd for addi, subi and movl
    assign req.opcode    = opcode;
    assign req.operand_a = use_rd ? regs[rd] : regs[insn.reg_form.rs];
    assign req.operand_b = is_lit ? literal : regs[insn.reg_form.rt];

    assign arith_start = issue & is_arith;
    assign logic_start = issue & is_logic;

    // track the one instruction in flight
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending     <= 1'b0;
            owner_arith <= 1'b0;
            bad_op      <= 1'b0;
            dest        <= '0;
        end else if (issue) begin
            pending     <= 1'b1;
            owner_arith <= is_arith;
            bad_op      <= ~(is_arith | is_logic);
            dest        <= rd;
        end else if (complete) begin
            pending <= 1'b0;
        end
    end

    // only the started unit counts
    assign owner_rsp  = owner_arith ? arith_rsp : logic_rsp;
    // bad opcode finishes the cycle after issue
    assign complete   = pending & (bad_op | owner_rsp.done);
    assign insn_error = pending & bad_op;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= (i == STACK_REG) ? STACK_RESET : '0;
            end
        end else begin
            // APB half writes
            if (reg_we) begin
                if (reg_hi) begin
                    regs[reg_idx][63:32] <= reg_wdata;
                end else begin
                    regs[reg_idx][31:0] <= reg_wdata;
                end
            end
            // writeback, nothing on error
            if (complete && !bad_op) begin
                regs[dest] <= owner_rsp.value;
            end
        end
    end

    assign rd_half_data = reg_hi ? regs[reg_idx][63:32] : regs[reg_idx][31:0];

    // a unit answers only to an issued instruction
    a_done_pending: assert property (@(posedge clk) disable iff (reset)
        (arith_rsp.done || logic_rsp.done) |-> pending);

    // the unit that was not started stays quiet
    a_owner_done: assert property (@(posedge clk) disable iff (reset)
        !(owner_arith ? logic_rsp.done : arith_rsp.done));

endmodule

/* hdl/tinker_exec.sv */
module tinker_exec #(
    parameter int MUL_STEPS = 64
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    import tinker_pkg::*;

    // APB side to register file
    logic        issue;
    insn_u       insn;
    logic        reg_we;
    reg_idx_t    reg_idx;
    logic        reg_hi;
    logic [31:0] reg_wdata;
    logic [31:0] rd_half_data;
    logic        complete;
    logic        insn_error;

    // dispatch and writeback
    unit_req_t   req;
    logic        arith_start;
    logic        logic_start;
    unit_rsp_t   arith_rsp;
    unit_rsp_t   logic_rsp;

    apb_port u_apb_port (.*);

    reg_file u_reg_file (.*);

    // both units see the same request, start picks the owner
    arith_unit #(
        .MUL_STEPS(MUL_STEPS)
    ) u_arith_unit (
        .clk  (clk),
        .reset(reset),
        .start(arith_start),
        .req  (req),
        .rsp  (arith_rsp)
    );

    logic_unit u_logic_unit (
        .clk  (clk),
        .reset(reset),
        .start(logic_start),
        .req  (req),
        .rsp  (logic_rsp)
    );

endmodule

/* hdl/tinker_pkg.sv */
package tinker_pkg;

    // machine dimensions
    localparam int WORD_W   = 64;
    localparam int NUM_REGS = 32;

    // r31 was the stack pointer, only its reset value survives
    localparam int          STACK_REG   = 31;
    localparam logic [63:0] STACK_RESET = 64'h80000;

    // APB map, each register is two 32-bit words, low half first
    localparam logic [11:0] ADDR_INSN     = 12'h000;
    localparam logic [11:0] ADDR_REG_BASE = 12'h100;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [4:0]        reg_idx_t;

    // kept opcodes, original encodings
    typedef enum logic [4:0] {
        OP_AND  = 5'b00000,
        OP_OR   = 5'b00001,
        OP_XOR  = 5'b00010,
        OP_NOT  = 5'b00011,
        OP_SHR  = 5'b00100,
        OP_SHRI = 5'b00101,
        OP_SHL  = 5'b00110,
        OP_SHLI = 5'b00111,
        OP_MOV  = 5'b10001,
        OP_MOVL = 5'b10010,
        OP_ADD  = 5'b11000,
        OP_ADDI = 5'b11001,
        OP_SUB  = 5'b11010,
        OP_SUBI = 5'b11011,
        OP_MUL  = 5'b11100
    } opcode_e;

    // three-register layout
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [11:0] pad;
    } reg_form_t;

    // literal layout, rt slot unused
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs;
        logic [4:0]  pad;
        logic [11:0] literal;
    } lit_form_t;

    // one instruction word, two views
    typedef union packed {
        reg_form_t reg_form;
        lit_form_t lit_form;
    } insn_u;

    // dispatch to both units
    typedef struct packed {
        opcode_e opcode;
        word_t   operand_a;
        word_t   operand_b;
    } unit_req_t;

    // done is a one-cycle pulse, value valid with it
    typedef struct packed {
        logic  done;
        word_t value;
    } unit_rsp_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the tinker_exec testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module tb_tinker_exec \
    --Mdir obj_dir \
    -f tinker_exec.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_tinker_exec > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "no result line found in sim.log"
    exit 1
fi
exit 0

/* tinker_exec.f */
hdl/tinker_pkg.sv
hdl/apb_port.sv
hdl/reg_file.sv
hdl/arith_unit.sv
hdl/logic_unit.sv
hdl/tinker_exec.sv
verification/tb_tinker_exec.sv

/* verification/exec_trace.txt */
# columns: test name, kind (W write, R read and compare, E insn write expecting pslverr),
# APB address and write data or expected read data, both hex
reset_values R 1F8 00080000
reset_values R 1FC 00000000
reset_values R 100 00000000
reset_values R 178 00000000
reset_values R 1F4 00000000
reg_access W 108 89ABCDEF
reg_access W 10C 01234567
reg_access R 108 89ABCDEF
reg_access R 10C 01234567
reg_access W 10C DEADBEEF
reg_access R 108 89ABCDEF
reg_access R 10C DEADBEEF
arith W 110 FFFFFFFF
arith W 114 FFFFFFFF
arith W 118 00000002
arith W 000 C1043000
arith R 120 00000001
arith R 124 00000000
arith W 000 D1883000
arith R 130 FFFFFFFF
arith R 134 FFFFFFFF
arith W 000 D1462000
arith R 128 00000003
arith W 000 C94207FF
arith R 128 00000802
arith W 000 D9420FFF
arith R 128 00000803
arith R 12C 00000000
arith W 000 C9000800
arith R 120 FFFFF801
arith R 124 FFFFFFFF
logic W 138 F0F0F0F0
logic W 13C 0F0F0F0F
logic W 000 02027000
logic R 140 80A0C0E0
logic R 144 0E0D0E0F
logic W 000 0A427000
logic R 148 F9FBFDFF
logic R 14C DFAFBFEF
logic W 000 12827000
logic R 150 795B3D1F
logic R 154 D1A2B1E0
logic W 000 1AC20000
logic R 158 76543210
logic R 15C 21524110
shift W 000 23023000
shift R 160 E26AF37B
shift R 164 37AB6FBB
shift W 000 3B420008
shift R 168 ABCDEF00
shift R 16C ADBEEF89
shift W 000 2B820024
shift R 170 0DEADBEE
shift R 174 00000000
shift W 178 00000055
shift W 000 33C22000
shift R 178 00000000
shift W 180 00000066
shift W 000 2C020040
shift R 180 00000000
move W 000 8C420000
move R 188 89ABCDEF
move R 18C DEADBEEF
move W 000 94400ABC
move R 188 89ABCABC
move R 18C DEADBEEF
mul W 198 00000003
mul W 19C 00000001
mul W 1A0 00000005
mul W 1A4 00000002
mul W 000 E4A74000
mul R 190 0000000F
mul R 194 0000000B
mul W 000 E5443000
mul R 1A8 FFFFFFFE
mul R 1AC FFFFFFFF
unsupported E 000 40443000
unsupported R 108 89ABCDEF
unsupported R 10C DEADBEEF
unsupported E 000 E9400000
unsupported R 128 00000803

/* verification/tb_tinker_exec.sv */
module tb_tinker_exec;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          MUL_STEPS  = 64;
    localparam logic [11:0] INSN_ADDR  = 12'h000;
    localparam logic [4:0]  MUL_OPCODE = 5'b11100;
    // longest access phase plus some margin
    localparam int          WAIT_LIMIT = MUL_STEPS + 8;
    localparam string       TRACE_FILE = "verification/exec_trace.txt";

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // trace columns, one entry per transfer
    string       t_name [$];
    byte         t_kind [$];
    logic [11:0] t_addr [$];
    logic [31:0] t_data [$];

    string       cur_name;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] rnd_state;
    bit          trace_ok;
    int          cycle_limit;
    int          cycle_count;

    tinker_exec #(.MUL_STEPS(MUL_STEPS)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // access cycles until pready, from the port timing
    function automatic int expected_cycles(input byte kind, input logic [11:0] addr,
                                           input logic [31:0] data);
        // register halves answer at once
        if (addr != INSN_ADDR) begin
            return 1;
        end
        // issue, unit done, then pready one cycle behind complete
        if (kind != "E" && data[31:27] == MUL_OPCODE) begin
            return MUL_STEPS + 2;
        end
        return 3;
    endfunction

    task automatic load_trace(output bit ok);
        int          fd;
        int          got;
        string       line;
        string       name;
        string       kind_s;
        logic [11:0] addr_v;
        logic [31:0] data_v;
        ok = 1'b0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                // skip comments and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%s %s %h %h", name, kind_s, addr_v, data_v);
                    if (got == 4) begin
                        t_name.push_back(name);
                        t_kind.push_back(kind_s.getc(0));
                        t_addr.push_back(addr_v);
                        t_data.push_back(data_v);
                    end
                end
            end
            $fclose(fd);
            ok = (t_name.size() > 0);
        end
    endtask

    // one APB transfer, setup then access until pready
    // entered on a falling edge, so transfers can run back to back
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err, output int cycles, output bit got);
        got    = 1'b0;
        rdata  = '0;
        err    = 1'b0;
        cycles = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        while (!got && cycles < WAIT_LIMIT) begin
            // sample mid low phase, clear of both edges
            #1;
            cycles++;
            if (pready) begin
                got   = 1'b1;
                rdata = prdata;
                err   = pslverr;
            end
            @(negedge clk);
        end
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_line(input int i);
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        bit          got;
        int          exp_cycles;
        logic        exp_err;
        logic [31:0] wdata;
        exp_cycles = expected_cycles(t_kind[i], t_addr[i], t_data[i]);
        exp_err    = (t_kind[i] == "E");
        wdata      = (t_kind[i] == "R") ? 32'h0 : t_data[i];
        // 0 to 3 idle cycles between transfers
        rnd_state = next_random(rnd_state);
        repeat (rnd_state[1:0]) @(negedge clk);
        apb_transfer(t_kind[i] != "R", t_addr[i], wdata, rdata, err, cycles, got);
        assert (got) else begin
            $display("test %s: no pready within %0d access cycles at address %h",
                     t_name[i], WAIT_LIMIT, t_addr[i]);
            test_errors++;
        end
        if (got) begin
            assert (cycles == exp_cycles) else begin
                $display("Mismatch in %s at %h: access cycles expected %0d, actual %0d",
                         t_name[i], t_addr[i], exp_cycles, cycles);
                test_errors++;
            end
            assert (err == exp_err) else begin
                $display("Mismatch in %s at %h: pslverr expected %0d, actual %0d",
                         t_name[i], t_addr[i], exp_err, err);
                test_errors++;
            end
            if (t_kind[i] == "R") begin
                assert (rdata == t_data[i]) else begin
                    $display("Mismatch in %s at %h: read data expected %h, actual %h",
                             t_name[i], t_addr[i], t_data[i], rdata);
                    test_errors++;
                end
            end
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", cur_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_name, test_errors);
        end
    endtask

    initial begin
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        rnd_state    = 32'h6281;
        cur_name     = "";
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("could not read any transfers from %s", TRACE_FILE);
            $display("Testbench failed");
        end else begin
            // worst case per line is a full multiply plus gaps
            cycle_limit = t_name.size() * (MUL_STEPS + 2 + 5) + 100;
            repeat (3) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            foreach (t_name[i]) begin
                // a new name closes the previous test
                if (t_name[i] != cur_name) begin
                    if (cur_name != "") begin
                        finish_test();
                    end
                    cur_name    = t_name[i];
                    test_errors = 0;
                end
                run_line(i);
            end
            finish_test();
            $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
            if (tests_failed == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
        end
        $finish;
    end

    // watchdog, armed once the trace length is known
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
        $display("Testbench failed");
        $finish;
    end

endmodule
